// File: src/ex_settings.svh
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// Data word width
`define EX_XLEN 32

// Multiplier pipeline depth, any value from 1 up
`define EX_MUL_STAGES 3

// One restoring step per quotient bit
`define EX_DIV_STEPS `EX_XLEN

`endif

// File: src/ex_pkg.sv
`default_nettype none

package ex_pkg;

	// Operation carried alongside the instruction word
	typedef enum logic [5:0] {
		OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
		OP_ADDI, OP_ADDIU,
		OP_SLT, OP_SLTU, OP_SLTI, OP_SLTIU,
		OP_AND, OP_OR, OP_XOR, OP_NOR,
		OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
		OP_SLL, OP_SRL, OP_SRA,
		OP_SLLV, OP_SRLV, OP_SRAV,
		OP_CLZ, OP_CLO,
		OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
		OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
		OP_BRANCH, OP_NOP
	} ex_op_e;

	// Branch conditions, encoded as in the decode stage
	typedef enum logic [2:0] {
		BR_EQ    = 3'b000,
		BR_NE    = 3'b001,
		BR_GEZ   = 3'b010,
		BR_GTZ   = 3'b011,
		BR_LEZ   = 3'b100,
		BR_LTZ   = 3'b101,
		BR_GEZAL = 3'b110,
		BR_LTZAL = 3'b111
	} br_cond_e;

	// Target of a move-to write
	typedef enum logic {
		HILO_HI,
		HILO_LO
	} hilo_sel_e;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] sa;
		logic [5:0] funct;
	} instr_r_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} instr_i_t;

	// Same 32 bits seen as R-type or I-type
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_word_u;

endpackage

`default_nettype wire

// File: src/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_settings.svh"

module ex_alu (
	input  ex_pkg::ex_op_e      op,
	input  ex_pkg::instr_word_u instr,
	input  logic [31:0]         rs_data,
	input  logic [31:0]         rt_data,
	output logic [31:0]         alu_out,
	output logic                ovf
);

	import ex_pkg::*;

	logic        imm_sel;
	logic        imm_sext;
	logic [31:0] imm_ext;
	logic [31:0] srcb;
	logic [31:0] sum;
	logic [31:0] diff;
	logic [4:0]  shamt;
	logic [31:0] cnt_src;
	logic [5:0]  lead_cnt;
	logic        ovf_en;
	logic        ovf_raw;

	// Immediate forms and their extension
	assign imm_sel = (op == OP_ADDI) || (op == OP_ADDIU) || (op == OP_SLTI) ||
		(op == OP_SLTIU) || (op == OP_ANDI) || (op == OP_ORI) || (op == OP_XORI);
	assign imm_sext = (op == OP_ADDI) || (op == OP_ADDIU) || (op == OP_SLTI) ||
		(op == OP_SLTIU);
	assign imm_ext = imm_sext ? {{16{instr.i.imm16[15]}}, instr.i.imm16} :
		{16'b0, instr.i.imm16};

	assign srcb = imm_sel ? imm_ext : rt_data;
	assign sum  = rs_data + srcb;
	assign diff = rs_data - srcb;

	// Variable shifts take the amount from rs
	assign shamt = ((op == OP_SLLV) || (op == OP_SRLV) || (op == OP_SRAV)) ?
		rs_data[4:0] : instr.r.sa;

	// CLO is CLZ of the inverted word
	assign cnt_src = (op == OP_CLO) ? ~rs_data : rs_data;

	always_comb begin
		lead_cnt = 6'(`EX_XLEN);
		// Highest set bit wins since it is visited last
		for (int k = 0; k < `EX_XLEN; k++) begin
			if (cnt_src[k])
				lead_cnt = 6'(`EX_XLEN - 1 - k);
		end
	end

	// Signed overflow, trapping forms only
	assign ovf_en = (op == OP_ADD) || (op == OP_ADDI) || (op == OP_SUB);
	assign ovf_raw = (op == OP_SUB) ?
		((rs_data[31] != srcb[31]) && (diff[31] != rs_data[31])) :
		((rs_data[31] == srcb[31]) && (sum[31] != rs_data[31]));
	assign ovf = ovf_en & ovf_raw;

	always_comb begin
		case (op)
			OP_ADD, OP_ADDU, OP_ADDI, OP_ADDIU:
				alu_out = sum;
			OP_SUB, OP_SUBU:
				alu_out = diff;
			OP_SLT, OP_SLTI:
				alu_out = {31'b0, $signed(rs_data) < $signed(srcb)};
			OP_SLTU, OP_SLTIU:
				alu_out = {31'b0, rs_data < srcb};
			OP_AND, OP_ANDI:
				alu_out = rs_data & srcb;
			OP_OR, OP_ORI:
				alu_out = rs_data | srcb;
			OP_XOR, OP_XORI:
				alu_out = rs_data ^ srcb;
			OP_NOR:
				alu_out = ~(rs_data | srcb);
			OP_LUI:
				alu_out = {instr.i.imm16, 16'b0};
			OP_SLL, OP_SLLV:
				alu_out = rt_data << shamt;
			OP_SRL, OP_SRLV:
				alu_out = rt_data >> shamt;
			OP_SRA, OP_SRAV:
				alu_out = $signed(rt_data) >>> shamt;
			OP_CLZ, OP_CLO:
				alu_out = {26'b0, lead_cnt};
			default:
				alu_out = 32'b0;
		endcase
	end

	always_comb begin
		if ((op == OP_ADDU) || (op == OP_ADDIU) || (op == OP_SUBU) ||
			(op == OP_SLTU) || (op == OP_SLTIU)) begin
			assert (!ovf) else $error("overflow flagged on unsigned op %s", op.name());
		end
	end

endmodule

`default_nettype wire

// File: src/ex_branch.sv
`timescale 1ns/1ps
`default_nettype none

module ex_branch (
	input  logic              valid,
	input  logic              is_branch,
	input  logic              guess_taken,
	input  ex_pkg::br_cond_e  cond,
	input  logic [31:0]       rs_data,
	input  logic [31:0]       rt_data,
	output logic              taken,
	output logic              mispredict
);

	import ex_pkg::*;

	logic equal;
	logic e0;
	logic g0;
	logic cond_hit;

	assign equal = (rs_data == rt_data);
	assign e0    = (rs_data == 32'd0);
	// Strictly positive
	assign g0    = ~rs_data[31] & ~e0;

	always_comb begin
		case (cond)
			BR_EQ:    cond_hit = equal;
			BR_NE:    cond_hit = !equal;
			BR_GEZ:   cond_hit = g0 | e0;
			BR_GTZ:   cond_hit = g0;
			BR_LEZ:   cond_hit = !g0;
			BR_LTZ:   cond_hit = !g0 && !e0;
			BR_GEZAL: cond_hit = g0 | e0;
			default:  cond_hit = !g0 && !e0;
		endcase
	end

	assign taken = valid & is_branch & cond_hit;

	// Wrong guess in either direction
	assign mispredict = valid & is_branch & (cond_hit != guess_taken);

endmodule

`default_nettype wire

// File: src/ex_mul.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_settings.svh"

module ex_mul (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        start,
	input  logic        is_signed,
	input  logic [31:0] srca,
	input  logic [31:0] srcb,
	output logic        done,
	output logic [31:0] hi,
	output logic [31:0] lo,
	output logic        in_flight
);

	localparam int STAGES = `EX_MUL_STAGES;

	logic signed [32:0] a_ext;
	logic signed [32:0] b_ext;
	logic signed [65:0] prod_full;
	logic [63:0]        prod_q [STAGES];
	logic [STAGES-1:0]  vld_q;

	// One extra bit makes unsigned operands non-negative
	assign a_ext = {is_signed & srca[31], srca};
	assign b_ext = {is_signed & srcb[31], srcb};
	assign prod_full = a_ext * b_ext;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vld_q <= '0;
		end else begin
			vld_q[0] <= start;
			for (int k = 1; k < STAGES; k++)
				vld_q[k] <= vld_q[k-1];
		end
	end

	always_ff @(posedge clk) begin
		prod_q[0] <= prod_full[63:0];
		for (int k = 1; k < STAGES; k++)
			prod_q[k] <= prod_q[k-1];
	end

	assign done      = vld_q[STAGES-1];
	assign hi        = prod_q[STAGES-1][63:32];
	assign lo        = prod_q[STAGES-1][31:0];
	assign in_flight = |vld_q;

	// Fixed latency, the HI/LO arbiter relies on it
	a_mul_latency: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> ##STAGES done);

endmodule

`default_nettype wire

// File: src/ex_div.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_settings.svh"

module ex_div (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        start,
	input  logic        is_signed,
	input  logic        ack,
	input  logic [31:0] srca,
	input  logic [31:0] srcb,
	output logic        busy,
	output logic        done,
	output logic [31:0] quot,
	output logic [31:0] rem
);

	localparam int CNT_W = $clog2(`EX_DIV_STEPS);

	logic [CNT_W-1:0] cnt_q;
	logic             running_q;
	logic             done_q;
	logic             last_step;
	logic [31:0]      a_mag;
	logic [31:0]      b_mag;
	logic [31:0]      rem_q;
	logic [31:0]      q_q;
	logic [31:0]      d_q;
	logic             qneg_q;
	logic             rneg_q;
	logic             dz_q;
	logic [32:0]      diff;

	assign a_mag = (is_signed && srca[31]) ? -srca : srca;
	assign b_mag = (is_signed && srcb[31]) ? -srcb : srcb;
	assign last_step = (cnt_q == CNT_W'(`EX_DIV_STEPS - 1));

	// Trial subtract of the divisor from the shifted partial remainder
	assign diff = {rem_q, q_q[31]} - {1'b0, d_q};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			running_q <= 1'b0;
			done_q    <= 1'b0;
			cnt_q     <= '0;
		end else if (start) begin
			running_q <= 1'b1;
			cnt_q     <= '0;
		end else if (running_q) begin
			cnt_q <= cnt_q + 1'b1;
			if (last_step) begin
				running_q <= 1'b0;
				done_q    <= 1'b1;
			end
		end else if (done_q && ack) begin
			done_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			rem_q  <= 32'b0;
			q_q    <= a_mag;
			d_q    <= b_mag;
			qneg_q <= is_signed & (srca[31] ^ srcb[31]);
			rneg_q <= is_signed & srca[31];
			dz_q   <= (srcb == 32'b0);
		end else if (running_q) begin
			rem_q <= diff[32] ? {rem_q[30:0], q_q[31]} : diff[31:0];
			q_q   <= {q_q[30:0], ~diff[32]};
		end
	end

	// Remainder takes the dividend sign
	assign quot = dz_q ? 32'hffff_ffff : (qneg_q ? -q_q : q_q);
	assign rem  = rneg_q ? -rem_q : rem_q;
	assign busy = running_q | done_q;
	assign done = done_q;

	a_div_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> !busy);

endmodule

`default_nettype wire

// File: src/ex_hilo.sv
`timescale 1ns/1ps
`default_nettype none

module ex_hilo (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              mul_done,
	input  logic              mul_in_flight,
	input  logic              div_busy,
	input  logic              div_done,
	input  logic [31:0]       mul_hi,
	input  logic [31:0]       mul_lo,
	input  logic [31:0]       div_quot,
	input  logic [31:0]       div_rem,
	input  logic [31:0]       mt_data,
	input  logic              mt_req,
	input  ex_pkg::hilo_sel_e mt_sel,
	input  logic              rd_req,
	output logic              div_ack,
	output logic              stall,
	output logic [31:0]       hi,
	output logic [31:0]       lo
);

	import ex_pkg::*;

	logic mul_pending;
	logic gnt_mul;
	logic gnt_mt;
	logic gnt_div;

	assign mul_pending = mul_done | mul_in_flight;

	// Multiplier cannot wait, then move-to, then divider
	assign gnt_mul = mul_done;
	assign gnt_mt  = mt_req & ~mul_pending;
	assign gnt_div = div_done & ~gnt_mul & ~gnt_mt;
	assign div_ack = gnt_div;

	// Moves and reads wait behind older HI/LO producers
	assign stall = (mt_req & mul_pending) | (rd_req & (mul_pending | div_busy));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hi <= 32'b0;
			lo <= 32'b0;
		end else if (gnt_mul) begin
			hi <= mul_hi;
			lo <= mul_lo;
		end else if (gnt_mt) begin
			if (mt_sel == HILO_HI)
				hi <= mt_data;
			else
				lo <= mt_data;
		end else if (gnt_div) begin
			hi <= div_rem;
			lo <= div_quot;
		end
	end

	a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({gnt_mul, gnt_mt, gnt_div}));

endmodule

`default_nettype wire

// File: src/ex_unit.sv
`timescale 1ns/1ps
`default_nettype none

module ex_unit (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                issue_valid,
	input  ex_pkg::ex_op_e      op,
	input  ex_pkg::br_cond_e    cond,
	input  ex_pkg::instr_word_u instr,
	input  logic [31:0]         rs_data,
	input  logic [31:0]         rt_data,
	input  logic                guess_taken,
	output logic                stall,
	output logic                result_valid,
	output logic                int_ovf,
	output logic                mispredict,
	output logic [31:0]         result,
	output logic [4:0]          reg_waddr,
	output logic [31:0]         hi,
	output logic [31:0]         lo
);

	import ex_pkg::*;

	logic        accept;
	logic        is_mult;
	logic        is_div;
	logic        is_mt;
	logic        is_mf;
	logic        is_imm;
	logic        is_branch;
	logic        is_link;
	logic        no_write;
	logic        hilo_stall;
	logic [31:0] alu_out;
	logic        alu_ovf;
	logic        mul_done;
	logic        mul_in_flight;
	logic [31:0] mul_hi;
	logic [31:0] mul_lo;
	logic        div_busy;
	logic        div_done;
	logic        div_ack;
	logic [31:0] div_quot;
	logic [31:0] div_rem;

	assign is_mult   = (op == OP_MULT) || (op == OP_MULTU);
	assign is_div    = (op == OP_DIV) || (op == OP_DIVU);
	assign is_mt     = (op == OP_MTHI) || (op == OP_MTLO);
	assign is_mf     = (op == OP_MFHI) || (op == OP_MFLO);
	assign is_branch = (op == OP_BRANCH);
	assign is_link   = is_branch && ((cond == BR_GEZAL) || (cond == BR_LTZAL));
	assign is_imm    = (op == OP_ADDI) || (op == OP_ADDIU) || (op == OP_SLTI) ||
		(op == OP_SLTIU) || (op == OP_ANDI) || (op == OP_ORI) || (op == OP_XORI) ||
		(op == OP_LUI);
	assign no_write  = is_mult || is_div || is_mt || (is_branch && !is_link) ||
		(op == OP_NOP);

	// A second divide waits for the first to drain
	assign stall  = hilo_stall | (issue_valid & is_div & div_busy);
	assign accept = issue_valid & ~stall;

	ex_alu u_alu (
		.op      (op),
		.instr   (instr),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.alu_out (alu_out),
		.ovf     (alu_ovf)
	);

	ex_branch u_branch (
		.valid       (accept),
		.is_branch   (is_branch),
		.guess_taken (guess_taken),
		.cond        (cond),
		.rs_data     (rs_data),
		.rt_data     (rt_data),
		.taken       (),
		.mispredict  (mispredict)
	);

	ex_mul u_mul (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (accept & is_mult),
		.is_signed (op == OP_MULT),
		.srca      (rs_data),
		.srcb      (rt_data),
		.done      (mul_done),
		.hi        (mul_hi),
		.lo        (mul_lo),
		.in_flight (mul_in_flight)
	);

	ex_div u_div (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (accept & is_div),
		.is_signed (op == OP_DIV),
		.ack       (div_ack),
		.srca      (rs_data),
		.srcb      (rt_data),
		.busy      (div_busy),
		.done      (div_done),
		.quot      (div_quot),
		.rem       (div_rem)
	);

	ex_hilo u_hilo (
		.clk           (clk),
		.rst_n         (rst_n),
		.mul_done      (mul_done),
		.mul_in_flight (mul_in_flight),
		.div_busy      (div_busy),
		.div_done      (div_done),
		.mul_hi        (mul_hi),
		.mul_lo        (mul_lo),
		.div_quot      (div_quot),
		.div_rem       (div_rem),
		.mt_data       (rs_data),
		.mt_req        (issue_valid & is_mt),
		.mt_sel        ((op == OP_MTHI) ? HILO_HI : HILO_LO),
		.rd_req        (issue_valid & is_mf),
		.div_ack       (div_ack),
		.stall         (hilo_stall),
		.hi            (hi),
		.lo            (lo)
	);

	// Link data arrives on rt
	always_comb begin
		if (op == OP_MFHI)
			result = hi;
		else if (op == OP_MFLO)
			result = lo;
		else if (is_link)
			result = rt_data;
		else
			result = alu_out;
	end

	assign reg_waddr = is_link ? 5'd31 : (is_imm ? instr.i.rt : instr.r.rd);
	assign result_valid = accept & ~no_write;
	assign int_ovf = accept & alu_ovf;

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Reset released on a rising edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// File: tests/ex_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_settings.svh"

module ex_unit_tb;

	import ex_pkg::*;

	localparam int MUL_STAGES = `EX_MUL_STAGES;
	localparam int N_ALU      = 200;
	localparam int N_BR_EACH  = 6;
	localparam int N_MUL      = 6;
	localparam int N_DIV      = 10;
	localparam int N_OPS      = N_ALU + 8 * N_BR_EACH + N_MUL + 2 + 3 * N_DIV + 4;

	logic        clk;
	logic        rst_n;
	logic        issue_valid;
	ex_op_e      op;
	br_cond_e    cond;
	instr_word_u instr;
	logic [31:0] rs_data;
	logic [31:0] rt_data;
	logic        guess_taken;

	// Reference model state
	logic                  acc_seen = 1'b0;
	logic [MUL_STAGES-1:0] mpipe_v;
	logic [63:0]           mpipe_p [MUL_STAGES];
	logic [31:0]           model_hi;
	logic [31:0]           model_lo;
	logic                  div_pend;
	logic                  exp_writes;
	logic [4:0]            exp_waddr;
	logic [31:0]           exp_result;
	logic                  exp_ovf;
	logic                  exp_mispredict;
	logic                  exp_stall;

	tb_clock u_clock (
		.clk   (clk),
		.rst_n (rst_n)
	);

	ex_unit dut_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.issue_valid  (issue_valid),
		.op           (op),
		.cond         (cond),
		.instr        (instr),
		.rs_data      (rs_data),
		.rt_data      (rt_data),
		.guess_taken  (guess_taken),
		.stall        (),
		.result_valid (),
		.int_ovf      (),
		.mispredict   (),
		.result       (),
		.reg_waddr    (),
		.hi           (),
		.lo           ()
	);

	function automatic logic [31:0] sext_imm(instr_word_u f_in);
		return {{16{f_in.i.imm16[15]}}, f_in.i.imm16};
	endfunction

	function automatic logic [31:0] alu_value(ex_op_e f_op, instr_word_u f_in,
		logic [31:0] a, logic [31:0] b);
		logic [31:0] simm;
		logic [31:0] zimm;
		logic [4:0]  sa;
		int          n;
		simm = sext_imm(f_in);
		zimm = {16'h0000, f_in.i.imm16};
		sa = f_in.r.sa;
		n = 0;
		case (f_op)
			OP_ADD, OP_ADDU:   return a + b;
			OP_ADDI, OP_ADDIU: return a + simm;
			OP_SUB, OP_SUBU:   return a - b;
			OP_SLT:            return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			OP_SLTU:           return (a < b) ? 32'd1 : 32'd0;
			OP_SLTI:           return ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
			OP_SLTIU:          return (a < simm) ? 32'd1 : 32'd0;
			OP_AND:            return a & b;
			OP_OR:             return a | b;
			OP_XOR:            return a ^ b;
			OP_NOR:            return ~(a | b);
			OP_ANDI:           return a & zimm;
			OP_ORI:            return a | zimm;
			OP_XORI:           return a ^ zimm;
			OP_LUI:            return zimm << 16;
			OP_SLL:            return b << sa;
			OP_SRL:            return b >> sa;
			OP_SRA:            return $signed(b) >>> sa;
			OP_SLLV:           return b << a[4:0];
			OP_SRLV:           return b >> a[4:0];
			OP_SRAV:           return $signed(b) >>> a[4:0];
			OP_CLZ, OP_CLO: begin
				// Walk down from the MSB while the bit matches the counted value
				while ((n < 32) && (a[31-n] == (f_op == OP_CLO)))
					n++;
				return 32'(n);
			end
			default:           return 32'd0;
		endcase
	endfunction

	function automatic logic signed_overflow(ex_op_e f_op, instr_word_u f_in,
		logic [31:0] a, logic [31:0] b);
		logic [32:0] wide;
		logic [31:0] simm;
		simm = sext_imm(f_in);
		case (f_op)
			OP_ADD:  wide = {a[31], a} + {b[31], b};
			OP_ADDI: wide = {a[31], a} + {simm[31], simm};
			OP_SUB:  wide = {a[31], a} - {b[31], b};
			default: return 1'b0;
		endcase
		// Top two bits of the 33-bit result disagree on overflow
		return wide[32] != wide[31];
	endfunction

	function automatic logic branch_taken(br_cond_e f_cond, logic [31:0] a, logic [31:0] b);
		case (f_cond)
			BR_EQ:            return a == b;
			BR_NE:            return a != b;
			BR_GTZ:           return $signed(a) > 0;
			BR_LEZ:           return $signed(a) <= 0;
			BR_GEZ, BR_GEZAL: return $signed(a) >= 0;
			default:          return $signed(a) < 0;
		endcase
	endfunction

	function automatic logic writes_register(ex_op_e f_op, br_cond_e f_cond);
		if (f_op == OP_BRANCH)
			return (f_cond == BR_GEZAL) || (f_cond == BR_LTZAL);
		return f_op inside {[OP_ADD:OP_CLO], OP_MFHI, OP_MFLO};
	endfunction

	function automatic logic [4:0] dest_register(ex_op_e f_op, br_cond_e f_cond,
		instr_word_u f_in);
		if ((f_op == OP_BRANCH) && ((f_cond == BR_GEZAL) || (f_cond == BR_LTZAL)))
			return 5'd31;
		if (f_op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI})
			return f_in.i.rt;
		return f_in.r.rd;
	endfunction

	function automatic logic [63:0] full_product(logic sgn, logic [31:0] a, logic [31:0] b);
		if (sgn)
			return longint'($signed(a)) * longint'($signed(b));
		return {32'd0, a} * {32'd0, b};
	endfunction

	// Result packed as remainder over quotient, the HI/LO layout
	function automatic logic [63:0] divide_pair(logic sgn, logic [31:0] a, logic [31:0] b);
		longint na;
		longint nb;
		longint q;
		longint r;
		if (b == 32'd0)
			return {a, 32'hffff_ffff};
		na = sgn ? longint'($signed(a)) : longint'({32'd0, a});
		nb = sgn ? longint'($signed(b)) : longint'({32'd0, b});
		q = na / nb;
		r = na % nb;
		return {r[31:0], q[31:0]};
	endfunction

	function automatic logic [31:0] pick_operand();
		case ($urandom_range(0, 7))
			0:       return 32'd0;
			1:       return 32'h7fff_ffff;
			2:       return 32'h8000_0000;
			3:       return 32'hffff_ffff;
			4:       return $urandom >> $urandom_range(0, 31);
			default: return $urandom;
		endcase
	endfunction

	task automatic report_mismatch(input string sig, input logic [31:0] got,
		input logic [31:0] want);
		$display("** Error at %0t: %s is %h, expected %h", $time, sig, got, want);
		$display(">>> FAIL");
		$fatal(1, "mismatch on %s", sig);
	endtask

	// Hold the operation until the unit takes it
	task automatic issue_op(input ex_op_e t_op, input br_cond_e t_cond,
		input logic [31:0] t_instr, input logic [31:0] t_rs, input logic [31:0] t_rt,
		input logic t_guess);
		@(posedge clk);
		issue_valid <= 1'b1;
		op          <= t_op;
		cond        <= t_cond;
		instr       <= t_instr;
		rs_data     <= t_rs;
		rt_data     <= t_rt;
		guess_taken <= t_guess;
		@(negedge clk);
		while (dut_i.stall)
			@(negedge clk);
	endtask

	task automatic go_idle(input int cycles);
		@(posedge clk);
		issue_valid <= 1'b0;
		op          <= OP_NOP;
		repeat (cycles) @(posedge clk);
	endtask

	task automatic run_divide(input logic sgn, input logic [31:0] a, input logic [31:0] b);
		issue_op(sgn ? OP_DIV : OP_DIVU, BR_EQ, $urandom, a, b, 1'b0);
		issue_op(OP_MFLO, BR_EQ, $urandom, 32'd0, 32'd0, 1'b0);
		issue_op(OP_MFHI, BR_EQ, $urandom, 32'd0, 32'd0, 1'b0);
	endtask

	always @(negedge clk)
		acc_seen <= issue_valid && !dut_i.stall;

	always_comb begin
		exp_writes = writes_register(op, cond);
		exp_waddr  = dest_register(op, cond, instr);
		case (op)
			OP_MFHI:   exp_result = model_hi;
			OP_MFLO:   exp_result = model_lo;
			OP_BRANCH: exp_result = rt_data;
			default:   exp_result = alu_value(op, instr, rs_data, rt_data);
		endcase
		exp_ovf = acc_seen && signed_overflow(op, instr, rs_data, rt_data);
		exp_mispredict = acc_seen && (op == OP_BRANCH) &&
			(branch_taken(cond, rs_data, rt_data) != guess_taken);
		exp_stall = issue_valid && (op inside {OP_MTHI, OP_MTLO, OP_MFHI, OP_MFLO}) &&
			(|mpipe_v);
	end

	// HI/LO model, products land MUL_STAGES cycles after acceptance
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mpipe_v  <= '0;
			model_hi <= 32'd0;
			model_lo <= 32'd0;
			div_pend <= 1'b0;
		end else begin
			mpipe_v[0] <= acc_seen && ((op == OP_MULT) || (op == OP_MULTU));
			mpipe_p[0] <= full_product(op == OP_MULT, rs_data, rt_data);
			for (int k = 1; k < MUL_STAGES; k++) begin
				mpipe_v[k] <= mpipe_v[k-1];
				mpipe_p[k] <= mpipe_p[k-1];
			end
			if (mpipe_v[MUL_STAGES-1])
				{model_hi, model_lo} <= mpipe_p[MUL_STAGES-1];
			else if (acc_seen && (op == OP_MTHI))
				model_hi <= rs_data;
			else if (acc_seen && (op == OP_MTLO))
				model_lo <= rs_data;
			// Divider timing is left open until a move-from drains it
			if (acc_seen && ((op == OP_DIV) || (op == OP_DIVU))) begin
				{model_hi, model_lo} <= divide_pair(op == OP_DIV, rs_data, rt_data);
				div_pend <= 1'b1;
			end else if (acc_seen && ((op == OP_MFLO) || (op == OP_MFHI))) begin
				div_pend <= 1'b0;
			end
		end
	end

	a_result: assert property (@(posedge clk) disable iff (!rst_n)
		(acc_seen && exp_writes) |-> (dut_i.result == exp_result))
		else report_mismatch("result", $sampled(dut_i.result), $sampled(exp_result));

	a_waddr: assert property (@(posedge clk) disable iff (!rst_n)
		(acc_seen && exp_writes) |-> (dut_i.reg_waddr == exp_waddr))
		else report_mismatch("reg_waddr", 32'($sampled(dut_i.reg_waddr)),
			32'($sampled(exp_waddr)));

	a_result_valid: assert property (@(posedge clk) disable iff (!rst_n)
		dut_i.result_valid == (acc_seen && exp_writes))
		else report_mismatch("result_valid", 32'($sampled(dut_i.result_valid)),
			32'($sampled(acc_seen && exp_writes)));

	a_ovf: assert property (@(posedge clk) disable iff (!rst_n)
		dut_i.int_ovf == exp_ovf)
		else report_mismatch("int_ovf", 32'($sampled(dut_i.int_ovf)), 32'($sampled(exp_ovf)));

	a_mispredict: assert property (@(posedge clk) disable iff (!rst_n)
		dut_i.mispredict == exp_mispredict)
		else report_mismatch("mispredict", 32'($sampled(dut_i.mispredict)),
			32'($sampled(exp_mispredict)));

	a_stall: assert property (@(posedge clk) disable iff (!rst_n)
		!div_pend |-> (dut_i.stall == exp_stall))
		else report_mismatch("stall", 32'($sampled(dut_i.stall)), 32'($sampled(exp_stall)));

	a_hi: assert property (@(posedge clk) disable iff (!rst_n)
		!div_pend |-> (dut_i.hi == model_hi))
		else report_mismatch("hi", $sampled(dut_i.hi), $sampled(model_hi));

	a_lo: assert property (@(posedge clk) disable iff (!rst_n)
		!div_pend |-> (dut_i.lo == model_lo))
		else report_mismatch("lo", $sampled(dut_i.lo), $sampled(model_lo));

	initial begin : watchdog
		repeat (N_OPS * (`EX_DIV_STEPS + 10)) @(posedge clk);
		$display("Timeout: the tests did not finish in %0d cycles", N_OPS * (`EX_DIV_STEPS + 10));
		$display(">>> FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin : stimulus
		logic [31:0] opnd;
		void'($urandom(32'h5c9a7905));
		issue_valid = 1'b0;
		op          = OP_NOP;
		cond        = BR_EQ;
		instr       = '0;
		rs_data     = 32'd0;
		rt_data     = 32'd0;
		guess_taken = 1'b0;
		@(posedge rst_n);
		repeat (2) @(posedge clk);

		for (int n = 0; n < N_ALU; n++)
			issue_op(ex_op_e'(6'($urandom_range(0, 25))), BR_EQ, $urandom,
				pick_operand(), pick_operand(), 1'b0);

		// Even trials use equal operands for the EQ and NE cases
		for (int c = 0; c < 8; c++) begin
			for (int k = 0; k < N_BR_EACH; k++) begin
				opnd = pick_operand();
				issue_op(OP_BRANCH, br_cond_e'(3'(c)), $urandom, opnd,
					(k % 2 == 0) ? opnd : pick_operand(), 1'($urandom_range(0, 1)));
			end
		end

		for (int k = 0; k < N_MUL; k++)
			issue_op((k % 2 == 0) ? OP_MULT : OP_MULTU, BR_EQ, $urandom,
				pick_operand(), pick_operand(), 1'b0);
		issue_op(OP_MFHI, BR_EQ, $urandom, 32'd0, 32'd0, 1'b0);
		issue_op(OP_MFLO, BR_EQ, $urandom, 32'd0, 32'd0, 1'b0);

		run_divide(1'b1, 32'd100, 32'd7);
		run_divide(1'b1, -32'sd100, 32'd7);
		run_divide(1'b1, 32'd100, -32'sd7);
		run_divide(1'b1, -32'sd100, -32'sd7);
		run_divide(1'b1, 32'd12345, 32'd0);
		run_divide(1'b1, -32'sd12345, 32'd0);
		run_divide(1'b0, 32'hffff_ffff, 32'd3);
		run_divide(1'b0, 32'h8000_0000, 32'd0);
		run_divide(1'b0, $urandom, $urandom_range(1, 65535));
		run_divide(1'b1, pick_operand(), pick_operand());

		// Moves right behind a product must wait for its write
		issue_op(OP_MULT, BR_EQ, $urandom, pick_operand(), pick_operand(), 1'b0);
		issue_op(OP_MTHI, BR_EQ, $urandom, 32'h1234_5678, 32'd0, 1'b0);
		issue_op(OP_MTLO, BR_EQ, $urandom, 32'h9abc_def0, 32'd0, 1'b0);
		issue_op(OP_MFHI, BR_EQ, $urandom, 32'd0, 32'd0, 1'b0);

		go_idle(MUL_STAGES + 4);
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+src
src/ex_pkg.sv
src/ex_alu.sv
src/ex_branch.sv
src/ex_mul.sv
src/ex_div.sv
src/ex_hilo.sv
src/ex_unit.sv
tests/tb_clock.sv
tests/ex_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ex_unit_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= >>> PASS

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
